//--- design/ray_core_pkg.sv
// ray core package: data widths, stage delays, state codes and the direction word union
package ray_core_pkg;

    // ------------------------------------------------------------
    // data widths
    // ------------------------------------------------------------

    // pixel coordinate width
    localparam int coord_bits = 10;

    // direction component is unsigned 8.8 fixed point
    localparam int frac_bits = 8;
    localparam int int_bits = 8;
    localparam int dir_bits = int_bits + frac_bits;

    // ------------------------------------------------------------
    // stage timing
    // ------------------------------------------------------------

    // cycles spent in the work state per item
    localparam int raster_work_cycles = 16;
    localparam int pass_work_cycles = 0;

    // work-delay counter, wide enough for raster_work_cycles
    localparam int count_bits = 5;

    // ------------------------------------------------------------
    // stage FSM encoding
    // ------------------------------------------------------------

    localparam int state_bits = 2;

    // idle waits for a full slot and moves it into the working register
    localparam logic [state_bits-1:0] state_idle = 2'd0;

    // item held for the stage's processing delay
    localparam logic [state_bits-1:0] state_work = 2'd1;

    // result waits for room downstream
    localparam logic [state_bits-1:0] state_done = 2'd2;

    // ------------------------------------------------------------
    // direction word
    // ------------------------------------------------------------

    // one direction component, read either as the whole fixed-point
    // value or split into integer and fraction fields
    typedef union packed {
        logic [dir_bits-1:0] value;
        struct packed {
            // integer byte, also used as a color channel
            logic [int_bits-1:0] int_part;
            logic [frac_bits-1:0] frac_part;
        } fields;
    } dir_word_t;

endpackage

//--- design/stage_control.sv
// stage_control: one-entry slot flag, idle/work/done FSM, work-delay counter, output strobe
`timescale 1ns/10ps

module stage_control #(
    // cycles spent in the work state, zero skips it
    parameter int work_cycles = ray_core_pkg::pass_work_cycles
) (
    input  logic clk,
    input  logic resetn,

    // item offered by the producer
    input  logic add_input,

    // next stage's slot is occupied
    input  logic output_fifo_full,

    // slot occupied, producer must hold
    output logic fifo_full,

    // slot moves into the working register this cycle
    output logic take,

    // working register moves to the output register this cycle
    output logic done,

    // one-cycle pulse with the new output data
    output logic valid
);

    logic [ray_core_pkg::state_bits-1:0] state;
    logic [ray_core_pkg::count_bits-1:0] work_count;

    // ------------------------------------------------------------
    // handshake strobes
    // ------------------------------------------------------------

    // slot is drained only from idle
    assign take = (state == ray_core_pkg::state_idle) && fifo_full;

    // result leaves as soon as the consumer has room
    assign done = (state == ray_core_pkg::state_done) && !output_fifo_full;

    // ------------------------------------------------------------
    // input slot flag
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            fifo_full <= 1'b0;
        end else if (take) begin
            // slot contents now live in the working register
            fifo_full <= 1'b0;
        end else if (add_input && !fifo_full) begin
            fifo_full <= 1'b1;
        end
    end

    // ------------------------------------------------------------
    // stage FSM and delay counter
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= ray_core_pkg::state_idle;
            work_count <= '0;
        end else begin
            case (state)
                ray_core_pkg::state_idle: begin
                    if (take) begin
                        work_count <= '0;
                        if (work_cycles == 0) begin
                            state <= ray_core_pkg::state_done;
                        end else begin
                            state <= ray_core_pkg::state_work;
                        end
                    end
                end

                ray_core_pkg::state_work: begin
                    work_count <= work_count + 1'b1;
                    // last work cycle reached
                    if (int'(work_count) + 1 >= work_cycles) begin
                        state <= ray_core_pkg::state_done;
                    end
                end

                ray_core_pkg::state_done: begin
                    // stall here while the next slot is full
                    if (!output_fifo_full) begin
                        state <= ray_core_pkg::state_idle;
                    end
                end

                default: begin
                    state <= ray_core_pkg::state_idle;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // output strobe
    // ------------------------------------------------------------

    // high for the cycle after the output register loads
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else begin
            valid <= done;
        end
    end

endmodule

//--- design/raster_stage.sv
// raster_stage: ray slot and working copy, fixed delay, direction-to-color output register
`timescale 1ns/10ps

module raster_stage (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                add_input,
    input  logic [ray_core_pkg::coord_bits-1:0] in_x,
    input  logic [ray_core_pkg::coord_bits-1:0] in_y,
    input  ray_core_pkg::dir_word_t             in_dir_x,
    input  ray_core_pkg::dir_word_t             in_dir_y,
    input  ray_core_pkg::dir_word_t             in_dir_z,
    input  logic                                output_fifo_full,
    output logic                                fifo_full,
    output logic                                valid,
    output logic [ray_core_pkg::coord_bits-1:0] out_x,
    output logic [ray_core_pkg::coord_bits-1:0] out_y,
    output logic [ray_core_pkg::int_bits-1:0]   out_red,
    output logic [ray_core_pkg::int_bits-1:0]   out_green,
    output logic [ray_core_pkg::int_bits-1:0]   out_blue
);

    logic accept;
    logic take;
    logic done;

    // input slot
    logic [ray_core_pkg::coord_bits-1:0] slot_x;
    logic [ray_core_pkg::coord_bits-1:0] slot_y;
    ray_core_pkg::dir_word_t             slot_dir_x;
    ray_core_pkg::dir_word_t             slot_dir_y;
    ray_core_pkg::dir_word_t             slot_dir_z;

    // ray being processed
    logic [ray_core_pkg::coord_bits-1:0] work_x;
    logic [ray_core_pkg::coord_bits-1:0] work_y;
    ray_core_pkg::dir_word_t             work_dir_x;
    ray_core_pkg::dir_word_t             work_dir_y;
    ray_core_pkg::dir_word_t             work_dir_z;

    assign accept = add_input && !fifo_full;

    stage_control #(
        .work_cycles(ray_core_pkg::raster_work_cycles)
    ) u_control (
        .clk(clk),
        .resetn(resetn),
        .add_input(add_input),
        .output_fifo_full(output_fifo_full),
        .fifo_full(fifo_full),
        .take(take),
        .done(done),
        .valid(valid)
    );

    // ------------------------------------------------------------
    // slot and working registers
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (accept) begin
            slot_x <= in_x;
            slot_y <= in_y;
            slot_dir_x <= in_dir_x;
            slot_dir_y <= in_dir_y;
            slot_dir_z <= in_dir_z;
        end
        if (take) begin
            work_x <= slot_x;
            work_y <= slot_y;
            work_dir_x <= slot_dir_x;
            work_dir_y <= slot_dir_y;
            work_dir_z <= slot_dir_z;
        end
    end

    // ------------------------------------------------------------
    // combine register
    // ------------------------------------------------------------

    // color channel is the integer byte of each direction component
    always_ff @(posedge clk) begin
        if (done) begin
            out_x <= work_x;
            out_y <= work_y;
            out_red <= work_dir_x.fields.int_part;
            out_green <= work_dir_y.fields.int_part;
            out_blue <= work_dir_z.fields.int_part;
        end
    end

endmodule

//--- design/pass_stage.sv
// pass_stage: pixel slot and working copy with output register, used for shadowing and shading
`timescale 1ns/10ps

module pass_stage (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                add_input,
    input  logic [ray_core_pkg::coord_bits-1:0] in_x,
    input  logic [ray_core_pkg::coord_bits-1:0] in_y,
    input  logic [ray_core_pkg::int_bits-1:0]   in_red,
    input  logic [ray_core_pkg::int_bits-1:0]   in_green,
    input  logic [ray_core_pkg::int_bits-1:0]   in_blue,
    input  logic                                output_fifo_full,
    output logic                                fifo_full,
    output logic                                valid,
    output logic [ray_core_pkg::coord_bits-1:0] out_x,
    output logic [ray_core_pkg::coord_bits-1:0] out_y,
    output logic [ray_core_pkg::int_bits-1:0]   out_red,
    output logic [ray_core_pkg::int_bits-1:0]   out_green,
    output logic [ray_core_pkg::int_bits-1:0]   out_blue
);

    logic accept;
    logic take;
    logic done;

    // slot and working copies, packed as {x, y, red, green, blue}
    logic [2*ray_core_pkg::coord_bits+3*ray_core_pkg::int_bits-1:0] slot_pixel;
    logic [2*ray_core_pkg::coord_bits+3*ray_core_pkg::int_bits-1:0] work_pixel;

    assign accept = add_input && !fifo_full;

    stage_control #(
        .work_cycles(ray_core_pkg::pass_work_cycles)
    ) u_control (
        .clk(clk),
        .resetn(resetn),
        .add_input(add_input),
        .output_fifo_full(output_fifo_full),
        .fifo_full(fifo_full),
        .take(take),
        .done(done),
        .valid(valid)
    );

    always_ff @(posedge clk) begin
        if (accept) begin
            slot_pixel <= {in_x, in_y, in_red, in_green, in_blue};
        end
        if (take) begin
            work_pixel <= slot_pixel;
        end
    end

    // combine register, pixel passes through unchanged
    always_ff @(posedge clk) begin
        if (done) begin
            {out_x, out_y, out_red, out_green, out_blue} <= work_pixel;
        end
    end

endmodule

//--- design/ray_core.sv
// ray_core: top level chaining the raster, shadowing and shader stages
`timescale 1ns/10ps

module ray_core (
    input  logic                                clk,
    input  logic                                resetn,

    // ray input
    input  logic                                add_input,
    input  logic [ray_core_pkg::coord_bits-1:0] in_x,
    input  logic [ray_core_pkg::coord_bits-1:0] in_y,
    input  ray_core_pkg::dir_word_t             in_dir_x,
    input  ray_core_pkg::dir_word_t             in_dir_y,
    input  ray_core_pkg::dir_word_t             in_dir_z,

    // frame buffer cannot take a pixel
    input  logic                                output_fifo_full,

    // pixel output
    output logic                                fifo_full,
    output logic                                valid,
    output logic [ray_core_pkg::coord_bits-1:0] out_x,
    output logic [ray_core_pkg::coord_bits-1:0] out_y,
    output logic [ray_core_pkg::int_bits-1:0]   out_red,
    output logic [ray_core_pkg::int_bits-1:0]   out_green,
    output logic [ray_core_pkg::int_bits-1:0]   out_blue
);

    // raster to shadowing
    logic                                raster_valid;
    logic [ray_core_pkg::coord_bits-1:0] raster_x;
    logic [ray_core_pkg::coord_bits-1:0] raster_y;
    logic [ray_core_pkg::int_bits-1:0]   raster_red;
    logic [ray_core_pkg::int_bits-1:0]   raster_green;
    logic [ray_core_pkg::int_bits-1:0]   raster_blue;
    logic                                shadow_fifo_full;

    // shadowing to shader
    logic                                shadow_valid;
    logic [ray_core_pkg::coord_bits-1:0] shadow_x;
    logic [ray_core_pkg::coord_bits-1:0] shadow_y;
    logic [ray_core_pkg::int_bits-1:0]   shadow_red;
    logic [ray_core_pkg::int_bits-1:0]   shadow_green;
    logic [ray_core_pkg::int_bits-1:0]   shadow_blue;
    logic                                shader_fifo_full;

    // ------------------------------------------------------------
    // pipeline: raster -> shadowing -> shader -> frame buffer
    // ------------------------------------------------------------

    raster_stage u_raster (
        .clk(clk),
        .resetn(resetn),
        .add_input(add_input),
        .in_x(in_x),
        .in_y(in_y),
        .in_dir_x(in_dir_x),
        .in_dir_y(in_dir_y),
        .in_dir_z(in_dir_z),
        .output_fifo_full(shadow_fifo_full),
        .fifo_full(fifo_full),
        .valid(raster_valid),
        .out_x(raster_x),
        .out_y(raster_y),
        .out_red(raster_red),
        .out_green(raster_green),
        .out_blue(raster_blue)
    );

    pass_stage u_shadow (
        .clk(clk),
        .resetn(resetn),
        .add_input(raster_valid),
        .in_x(raster_x),
        .in_y(raster_y),
        .in_red(raster_red),
        .in_green(raster_green),
        .in_blue(raster_blue),
        .output_fifo_full(shader_fifo_full),
        .fifo_full(shadow_fifo_full),
        .valid(shadow_valid),
        .out_x(shadow_x),
        .out_y(shadow_y),
        .out_red(shadow_red),
        .out_green(shadow_green),
        .out_blue(shadow_blue)
    );

    // last stage stalls on the frame buffer level
    pass_stage u_shader (
        .clk(clk),
        .resetn(resetn),
        .add_input(shadow_valid),
        .in_x(shadow_x),
        .in_y(shadow_y),
        .in_red(shadow_red),
        .in_green(shadow_green),
        .in_blue(shadow_blue),
        .output_fifo_full(output_fifo_full),
        .fifo_full(shader_fifo_full),
        .valid(valid),
        .out_x(out_x),
        .out_y(out_y),
        .out_red(out_red),
        .out_green(out_green),
        .out_blue(out_blue)
    );

endmodule

//--- include/tb_ray_core_vectors.svh
// stimulus table rows for the ray core testbench
// columns: test, x, y, dir_x, dir_y, dir_z (unsigned 8.8), stall cycles, back-to-back

// lone rays, pipeline empty before each
add_row(1, 10'd0, 10'd0, 16'h1234, 16'h5678, 16'h9abc, 0, 1'b0);
add_row(2, 10'd1023, 10'd767, 16'hffff, 16'h0000, 16'h80ff, 0, 1'b0);
add_row(3, 10'h155, 10'h2aa, 16'h7f01, 16'h0180, 16'hfe7f, 0, 1'b0);

// burst offered back to back, later rays get random directions
add_row(4, 10'd16, 10'd32, 16'h2040, 16'h6080, 16'ha0c0, 0, 1'b1);

// frame buffer stall on a lone ray, then on a burst long enough to fill every slot
add_row(5, 10'd100, 10'd200, 16'h3311, 16'h4422, 16'h5533, 30, 1'b0);
add_row(6, 10'd300, 10'd400, 16'hc001, 16'hd002, 16'he003, 150, 1'b1);

add_row(7, 10'd500, 10'd100, 16'h0102, 16'h0304, 16'h0506, 0, 1'b1);
add_row(8, 10'd1, 10'd2, 16'hff00, 16'h00ff, 16'h7777, 0, 1'b0);

//--- sim/tb_ray_core.sv
// tb_ray_core: clock, reset, DUT, table-driven stimulus, output monitor, checks and timeout
`timescale 1ns/10ps

module tb_ray_core;

    localparam int burst_rays = 6;

    // raster holds 2 + work cycles, each pass stage adds accept plus two
    localparam int lone_latency = 2 + ray_core_pkg::raster_work_cycles
                                + 2 * (3 + ray_core_pkg::pass_work_cycles);

    typedef struct packed {
        logic [7:0]                          test_num;
        logic [ray_core_pkg::coord_bits-1:0] x;
        logic [ray_core_pkg::coord_bits-1:0] y;
        logic [ray_core_pkg::dir_bits-1:0]   dir_x;
        logic [ray_core_pkg::dir_bits-1:0]   dir_y;
        logic [ray_core_pkg::dir_bits-1:0]   dir_z;
        logic [15:0]                         stall_cycles;
        logic                                back_to_back;
    } vector_t;

    typedef struct packed {
        logic [ray_core_pkg::coord_bits-1:0] x;
        logic [ray_core_pkg::coord_bits-1:0] y;
        logic [ray_core_pkg::int_bits-1:0]   red;
        logic [ray_core_pkg::int_bits-1:0]   green;
        logic [ray_core_pkg::int_bits-1:0]   blue;
        logic [31:0]                         accept_cycle;
        logic                                check_latency;
    } pixel_t;

    logic                                clk;
    logic                                resetn;
    logic                                add_input;
    logic [ray_core_pkg::coord_bits-1:0] in_x;
    logic [ray_core_pkg::coord_bits-1:0] in_y;
    ray_core_pkg::dir_word_t             in_dir_x;
    ray_core_pkg::dir_word_t             in_dir_y;
    ray_core_pkg::dir_word_t             in_dir_z;
    logic                                output_fifo_full;
    logic                                fifo_full;
    logic                                valid;
    logic [ray_core_pkg::coord_bits-1:0] out_x;
    logic [ray_core_pkg::coord_bits-1:0] out_y;
    logic [ray_core_pkg::int_bits-1:0]   out_red;
    logic [ray_core_pkg::int_bits-1:0]   out_green;
    logic [ray_core_pkg::int_bits-1:0]   out_blue;

    vector_t     vectors[$];
    pixel_t      expected_queue[$];
    pixel_t      seen_pixel;
    int          cycle_count = 0;
    int          timeout_limit = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          tests_failed = 0;
    int          errors_before;
    int          seed = 23895;
    logic [31:0] rand_word;

    ray_core i_ray_core (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // channel is the integer byte of the 8.8 word
    function automatic logic [ray_core_pkg::int_bits-1:0] color_of(
        input ray_core_pkg::dir_word_t dir);
        return dir.value[ray_core_pkg::dir_bits-1:ray_core_pkg::frac_bits];
    endfunction

    task automatic add_row(input int test_num, input logic [9:0] x, input logic [9:0] y,
                           input logic [15:0] dir_x, input logic [15:0] dir_y,
                           input logic [15:0] dir_z, input int stall_cycles,
                           input logic back_to_back);
        vector_t row;
        row.test_num = test_num[7:0];
        row.x = x;
        row.y = y;
        row.dir_x = dir_x;
        row.dir_y = dir_y;
        row.dir_z = dir_z;
        row.stall_cycles = stall_cycles[15:0];
        row.back_to_back = back_to_back;
        vectors.push_back(row);
    endtask

    task automatic load_table();
        `include "tb_ray_core_vectors.svh"
    endtask

    // called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic offer_ray(input logic [ray_core_pkg::coord_bits-1:0] x,
                             input logic [ray_core_pkg::coord_bits-1:0] y,
                             input ray_core_pkg::dir_word_t dir_x,
                             input ray_core_pkg::dir_word_t dir_y,
                             input ray_core_pkg::dir_word_t dir_z,
                             input logic check_latency);
        pixel_t entry;
        in_x = x;
        in_y = y;
        in_dir_x = dir_x;
        in_dir_y = dir_y;
        in_dir_z = dir_z;
        add_input = 1'b1;
        // hold the ray while the raster slot is busy
        while (fifo_full) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        entry.x = x;
        entry.y = y;
        entry.red = color_of(dir_x);
        entry.green = color_of(dir_y);
        entry.blue = color_of(dir_z);
        entry.accept_cycle = cycle_count;
        entry.check_latency = check_latency;
        expected_queue.push_back(entry);
        check_value("fifo_full", 1, fifo_full);
    endtask

    task automatic hold_output(input int stall_cycles, input logic expect_full);
        int n;
        if (stall_cycles != 0) begin
            output_fifo_full = 1'b1;
            for (n = 0; n < stall_cycles; n++) begin
                @(negedge clk);
                check_value("valid", 0, valid);
            end
            // every slot should be occupied by now
            if (expect_full) begin
                check_value("fifo_full", 1, fifo_full);
            end
            @(posedge clk);
            #1;
            output_fifo_full = 1'b0;
        end
    endtask

    task automatic run_row(input vector_t row);
        int                                  ray_count;
        int                                  i;
        logic [ray_core_pkg::coord_bits-1:0] ray_x;
        ray_core_pkg::dir_word_t             dx;
        ray_core_pkg::dir_word_t             dy;
        ray_core_pkg::dir_word_t             dz;
        ray_count = row.back_to_back ? burst_rays : 1;
        @(posedge clk);
        #1;
        fork
            hold_output(row.stall_cycles, row.back_to_back);
            begin
                for (i = 0; i < ray_count; i++) begin
                    ray_x = row.x + i;
                    if (i == 0) begin
                        dx.value = row.dir_x;
                        dy.value = row.dir_y;
                        dz.value = row.dir_z;
                    end else begin
                        rand_word = $urandom();
                        dx.value = rand_word[15:0];
                        dy.value = rand_word[31:16];
                        rand_word = $urandom();
                        dz.value = rand_word[15:0];
                    end
                    offer_ray(ray_x, row.y, dx, dy, dz,
                              row.stall_cycles == 0 && !row.back_to_back);
                end
                add_input = 1'b0;
            end
        join
        // drain the pipeline before the next row
        while (expected_queue.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    // ------------------------------------------------------------
    // output monitor
    // ------------------------------------------------------------

    always @(negedge clk) begin
        if (resetn && valid) begin
            if (expected_queue.size() == 0) begin
                $display("error: pixel (%0d, %0d) came out with no ray outstanding",
                         out_x, out_y);
                error_count++;
            end else begin
                seen_pixel = expected_queue.pop_front();
                check_value("out_x", seen_pixel.x, out_x);
                check_value("out_y", seen_pixel.y, out_y);
                check_value("out_red", seen_pixel.red, out_red);
                check_value("out_green", seen_pixel.green, out_green);
                check_value("out_blue", seen_pixel.blue, out_blue);
                if (seen_pixel.check_latency) begin
                    check_value("latency", lone_latency,
                                cycle_count - seen_pixel.accept_cycle);
                end
            end
        end
    end

    initial begin
        wait (timeout_limit != 0);
        while (cycle_count < timeout_limit) begin
            @(negedge clk);
        end
        $display("timeout: run did not finish within %0d cycles", timeout_limit);
        $display("Test FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        rand_word = $urandom(seed);
        resetn = 1'b0;
        add_input = 1'b0;
        in_x = '0;
        in_y = '0;
        in_dir_x = '0;
        in_dir_y = '0;
        in_dir_z = '0;
        output_fifo_full = 1'b0;
        load_table();
        timeout_limit = vectors.size() * 60 + 200;
        foreach (vectors[k]) begin
            timeout_limit += vectors[k].stall_cycles;
        end
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;

        // outputs idle after reset
        errors_before = error_count;
        repeat (4) begin
            @(negedge clk);
            check_value("valid", 0, valid);
            check_value("fifo_full", 0, fifo_full);
        end
        $display("test 0: reset state, %0d error(s)", error_count - errors_before);
        if (error_count != errors_before) begin
            tests_failed++;
        end

        foreach (vectors[k]) begin
            errors_before = error_count;
            run_row(vectors[k]);
            $display("test %0d: %0d ray(s), stall %0d, %0d error(s)", vectors[k].test_num,
                     vectors[k].back_to_back ? burst_rays : 1, vectors[k].stall_cycles,
                     error_count - errors_before);
            if (error_count != errors_before) begin
                tests_failed++;
            end
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors", vectors.size() + 1,
                 tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- ray_core.f
+incdir+include
design/ray_core_pkg.sv
design/stage_control.sv
design/raster_stage.sv
design/pass_stage.sv
design/ray_core.sv
sim/tb_ray_core.sv
